// ==== Bender.yml ====
package:
  name: soc_bus

export_include_dirs:
  - source

sources:
  - source/soc_pkg.sv
  - source/address_decoder.sv
  - source/apb_bridge.sv
  - source/apb_ram.sv
  - source/led_regs.sv
  - source/uart_tx.sv
  - source/soc_bus.sv
  - target: test
    files:
      - dv/bus_checker.sv
      - dv/tb_soc_bus.sv

// ==== dv/bus_checker.sv ====
//**************************************************
// Response and serial line checker for soc_bus
// Samples on the falling clock edge
// Assumes one request in flight at a time
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module bus_checker #(
  parameter int UART_CLKS_PER_BIT = 8
) (
  input wire logic        CLOCK_50_B5B,
  input wire logic        i_reset,
  input wire logic        i_req_valid,
  input wire logic        i_ready,
  input wire logic [31:0] i_rdata,
  input wire logic        i_error,
  input wire logic [9:0]  i_leds,
  input wire logic        i_uart_tx
);

  localparam int HALF_BIT = UART_CLKS_PER_BIT / 2 - 1;

  // Expected response of one request
  typedef struct packed {
    logic        check_rdata;
    logic [31:0] rdata;
    logic        error;
    int          latency;
  } resp_exp_t;

  string       test_name = "none";
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  resp_exp_t   exp_q [$];
  resp_exp_t   exp_cur;
  int          latency = 0;
  logic [7:0]  byte_q [$];
  logic        rx_active = 1'b0;
  int          rx_cnt;
  int          bit_idx;
  logic [7:0]  rx_byte;
  logic [7:0]  rx_expected;
  int          idle_cycles = 0;

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("FAIL %s: %s", test_name, msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%-20s ok", test_name);
    end else begin
      tests_bad++;
      $display("%-20s FAILED with %0d errors", test_name, test_errors);
    end
  endtask

  // Latency below zero means the completer may stall
  task automatic expect_resp(input logic check_rdata, input logic [31:0] rdata,
                             input logic error, input int lat);
    resp_exp_t e;
    e.check_rdata = check_rdata;
    e.rdata = rdata;
    e.error = error;
    e.latency = lat;
    exp_q.push_back(e);
  endtask

  task automatic check_leds(input logic [9:0] exp);
    compare_word("o_leds", 32'(exp), 32'(i_leds));
  endtask

  task automatic check_reset_state();
    compare_word("o_leds", 32'h0, 32'(i_leds));
    compare_word("o_uart_tx", 32'h1, 32'(i_uart_tx));
    compare_word("o_ready", 32'h0, 32'(i_ready));
  endtask

  task automatic push_byte(input logic [7:0] b);
    byte_q.push_back(b);
  endtask

  function automatic int bytes_pending();
    return byte_q.size();
  endfunction

  function automatic int line_idle_cycles();
    return idle_cycles;
  endfunction

  function automatic int error_total();
    return total_errors;
  endfunction

  task automatic print_counts();
    $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, total_errors);
  endtask

  // Response check, latency counts cycles with valid high before o_ready
  always @(negedge CLOCK_50_B5B) begin
    if (i_reset) begin
      latency = 0;
    end else if (i_ready) begin
      if (exp_q.size() == 0) begin
        note_failure("o_ready pulsed with no request pending");
      end else begin
        exp_cur = exp_q.pop_front();
        compare_word("o_error", 32'(exp_cur.error), 32'(i_error));
        if (exp_cur.check_rdata) begin
          compare_word("o_rdata", exp_cur.rdata, i_rdata);
        end
        if (exp_cur.latency >= 0) begin
          compare_word("latency", exp_cur.latency, latency);
        end
      end
      latency = 0;
    end else if (i_req_valid) begin
      latency++;
    end
  end

  // 8N1 frame decode, each bit sampled near its middle
  always @(negedge CLOCK_50_B5B) begin
    if (i_reset) begin
      rx_active = 1'b0;
      idle_cycles = 0;
    end else begin
      // Idle time only counts once a frame has ended
      idle_cycles = (i_uart_tx && !rx_active) ? idle_cycles + 1 : 0;
      if (!rx_active) begin
        if (!i_uart_tx) begin
          rx_active = 1'b1;
          rx_cnt = 0;
        end
      end else begin
        rx_cnt++;
        if (rx_cnt == HALF_BIT && i_uart_tx) begin
          note_failure("start bit on o_uart_tx did not stay low");
          rx_active = 1'b0;
        end else if (rx_cnt > HALF_BIT && (rx_cnt - HALF_BIT) % UART_CLKS_PER_BIT == 0) begin
          bit_idx = (rx_cnt - HALF_BIT) / UART_CLKS_PER_BIT - 1;
          if (bit_idx < 8) begin
            rx_byte[bit_idx] = i_uart_tx;
          end else begin
            rx_active = 1'b0;
            if (!i_uart_tx) begin
              note_failure("stop bit on o_uart_tx was low");
            end
            if (byte_q.size() == 0) begin
              note_failure("serial frame seen with no byte expected");
            end else begin
              rx_expected = byte_q.pop_front();
              compare_word("uart byte", 32'(rx_expected), 32'(rx_byte));
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_soc_bus.sv ====
//**************************************************
// Random requests from a 16-bit LFSR, seed 25
// UART bit period shortened to 8 clocks
// RAM reads only target words written earlier
//**************************************************
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module tb_soc_bus
  import soc_pkg::*;
();

  localparam int UART_BIT = 8;
  localparam int READY_TIMEOUT = 2000;
  localparam int UART_TIMEOUT = 5000;
  localparam logic [31:0] UART_DATA = `SOC_UART_BASE + `SOC_UART_DATA_OFS;
  localparam logic [31:0] UART_STATUS = `SOC_UART_BASE + `SOC_UART_STATUS_OFS;

  logic        clk;
  logic        reset;
  logic        req_valid;
  cpu_req_t    req;
  logic        ready;
  logic [31:0] rdata;
  logic        error;
  logic [9:0]  leds;
  logic        uart_tx;
  logic [15:0] lfsr;
  logic [31:0] ram_model [`SOC_RAM_WORDS];
  bit          ram_written [`SOC_RAM_WORDS];
  int          written_q [$];
  logic [9:0]  led_model;
  logic        timed_out;

  soc_bus #(
    .UART_CLKS_PER_BIT (UART_BIT)
  ) uut (
    .CLOCK_50_B5B (clk),
    .i_reset      (reset),
    .i_req_valid  (req_valid),
    .i_req        (req),
    .o_ready      (ready),
    .o_rdata      (rdata),
    .o_error      (error),
    .o_leds       (leds),
    .o_uart_tx    (uart_tx)
  );

  bus_checker #(
    .UART_CLKS_PER_BIT (UART_BIT)
  ) chk (
    .CLOCK_50_B5B (clk),
    .i_reset      (reset),
    .i_req_valid  (req_valid),
    .i_ready      (ready),
    .i_rdata      (rdata),
    .i_error      (error),
    .i_leds       (leds),
    .i_uart_tx    (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic is_mapped(input logic [31:0] a);
    return ((a - `SOC_RAM_BASE) < `SOC_RAM_SIZE) || ((a - `SOC_LED_BASE) < `SOC_LED_SIZE) ||
           ((a - `SOC_UART_BASE) < `SOC_UART_SIZE);
  endfunction

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready && cycles < READY_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ready) begin
      chk.note_failure("no o_ready from the DUT within the timeout");
      timed_out = 1'b1;
    end
  endtask

  task automatic issue_request(input logic [31:0] addr, input logic write,
                               input logic [31:0] wdata, input logic check_rdata,
                               input logic [31:0] exp_rdata, input logic exp_error,
                               input int exp_lat);
    if (timed_out) return;
    chk.expect_resp(check_rdata, exp_rdata, exp_error, exp_lat);
    @(posedge clk);
    #1;
    req.addr = addr;
    req.write = write;
    req.wdata = wdata;
    req_valid = 1'b1;
    wait_ready();
    req_valid = 1'b0;
  endtask

  // Idle means nothing left to receive and the line high for two bit times
  task automatic wait_uart_idle();
    int cycles;
    if (timed_out) return;
    cycles = 0;
    while (!(chk.bytes_pending() == 0 && chk.line_idle_cycles() >= 2 * UART_BIT) &&
           cycles < UART_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= UART_TIMEOUT) begin
      chk.note_failure("UART line did not return to idle within the timeout");
      timed_out = 1'b1;
    end
  endtask

  task automatic ram_write(input logic [12:0] idx, input logic [31:0] data);
    issue_request(`SOC_RAM_BASE + (32'(idx) << 2), 1'b1, data, 1'b0, '0, 1'b0, 3);
    ram_model[idx] = data;
    if (!ram_written[idx]) begin
      ram_written[idx] = 1'b1;
      written_q.push_back(idx);
    end
  endtask

  task automatic ram_read(input logic [12:0] idx);
    issue_request(`SOC_RAM_BASE + (32'(idx) << 2), 1'b0, '0, 1'b1, ram_model[idx], 1'b0, 3);
  endtask

  task automatic uart_data_write(input logic [7:0] b);
    chk.push_byte(b);
    issue_request(UART_DATA, 1'b1, {24'(rand_bits(24)), b}, 1'b0, '0, 1'b0, -1);
  endtask

  task automatic reset_test();
    chk.start_test("reset_values");
    chk.check_reset_state();
    chk.finish_test();
  endtask

  task automatic ram_test();
    logic [12:0] idx;
    chk.start_test("ram_random");
    repeat (24) begin
      idx = 13'(rand_bits(13));
      ram_write(idx, rand_bits(32));
    end
    repeat (48) begin
      if (lfsr_bit()) begin
        idx = 13'(rand_bits(13));
        ram_write(idx, rand_bits(32));
      end else begin
        idx = 13'(written_q[rand_bits(8) % written_q.size()]);
        ram_read(idx);
      end
    end
    chk.finish_test();
  endtask

  task automatic led_test();
    logic [31:0] data;
    chk.start_test("led_register");
    repeat (8) begin
      data = rand_bits(32);
      issue_request(`SOC_LED_BASE + (rand_bits(26) << 2), 1'b1, data, 1'b0, '0, 1'b0, 3);
      led_model = data[9:0];
      chk.check_leds(led_model);
      issue_request(`SOC_LED_BASE + (rand_bits(26) << 2), 1'b0, '0, 1'b1,
                    {22'b0, led_model}, 1'b0, 3);
    end
    chk.finish_test();
  endtask

  task automatic uart_frame_test();
    chk.start_test("uart_frame");
    repeat (4) begin
      uart_data_write(8'(rand_bits(8)));
      wait_uart_idle();
    end
    chk.finish_test();
  endtask

  task automatic uart_backpressure_test();
    chk.start_test("uart_backpressure");
    repeat (4)
      uart_data_write(8'(rand_bits(8)));
    issue_request(UART_STATUS, 1'b0, '0, 1'b1, 32'(1) << `SOC_UART_BUSY_BIT, 1'b0, 3);
    wait_uart_idle();
    issue_request(UART_STATUS, 1'b0, '0, 1'b1, 32'h0, 1'b0, 3);
    chk.finish_test();
  endtask

  task automatic error_test();
    logic [31:0] addr;
    chk.start_test("error_response");
    repeat (6) begin
      addr = rand_bits(32);
      for (int i = 0; i < 16 && is_mapped(addr); i++)
        addr = rand_bits(32);
      if (is_mapped(addr)) begin
        addr = 32'hF000_0000;
      end
      issue_request(addr, lfsr_bit(), rand_bits(32), 1'b1, 32'h0, 1'b1, 1);
    end
    // Just past the end of the RAM window
    issue_request(`SOC_RAM_BASE + `SOC_RAM_SIZE, 1'b1, rand_bits(32), 1'b1, 32'h0, 1'b1, 1);
    issue_request(UART_STATUS, 1'b1, rand_bits(32), 1'b1, 32'h0, 1'b1, 3);
    issue_request(UART_DATA, 1'b0, '0, 1'b1, 32'h0, 1'b1, 3);
    // Nothing above may have touched the peripherals
    chk.check_leds(led_model);
    issue_request(`SOC_LED_BASE, 1'b0, '0, 1'b1, {22'b0, led_model}, 1'b0, 3);
    for (int i = 0; i < 4 && i < written_q.size(); i++)
      ram_read(13'(written_q[i]));
    wait_uart_idle();
    chk.finish_test();
  endtask

  initial begin
    lfsr = 16'd25;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    led_model = '0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_test();
    ram_test();
    led_test();
    uart_frame_test();
    uart_backpressure_test();
    error_test();
    chk.print_counts();
    if (chk.error_total() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/soc_pkg.sv
source/address_decoder.sv
source/apb_bridge.sv
source/apb_ram.sv
source/led_regs.sv
source/uart_tx.sv
source/soc_bus.sv
dv/bus_checker.sv
dv/tb_soc_bus.sv

// ==== source/address_decoder.sv ====
//**************************************************
// Combinational address decoder
// Addresses outside all windows decode to NONE
// with a zero offset
//**************************************************
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module address_decoder
  import soc_pkg::*;
(
  input  wire cpu_req_t     i_req,
  output decoded_req_t      o_dec
);

  // Base inclusive, end exclusive
  function automatic logic in_window(
    input logic [31:0] addr,
    input logic [31:0] base,
    input logic [31:0] size
  );
    return (addr >= base) && ((addr - base) < size);
  endfunction

  always_comb begin
    o_dec.write = i_req.write;
    o_dec.wdata = i_req.wdata;

    if (in_window(i_req.addr, `SOC_RAM_BASE, `SOC_RAM_SIZE)) begin
      o_dec.region = REGION_RAM;
      o_dec.offset = i_req.addr - `SOC_RAM_BASE;
    end else if (in_window(i_req.addr, `SOC_LED_BASE, `SOC_LED_SIZE)) begin
      o_dec.region = REGION_LED;
      o_dec.offset = i_req.addr - `SOC_LED_BASE;
    end else if (in_window(i_req.addr, `SOC_UART_BASE, `SOC_UART_SIZE)) begin
      o_dec.region = REGION_UART;
      o_dec.offset = i_req.addr - `SOC_UART_BASE;
    end else begin
      // Unmapped, no APB transfer follows
      o_dec.region = REGION_NONE;
      o_dec.offset = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/apb_bridge.sv ====
//**************************************************
// APB master for one outstanding request
// i_dec must stay stable while i_req_valid is high
// o_ready pulses one cycle, o_rdata is zero on error
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module apb_bridge
  import soc_pkg::*;
(
  input  wire logic         CLOCK_50_B5B,
  input  wire logic         i_reset,
  input  wire logic         i_req_valid,
  input  wire decoded_req_t i_dec,
  output apb_req_t          o_apb,
  output logic              o_psel_ram,
  output logic              o_psel_led,
  output logic              o_psel_uart,
  input  wire apb_rsp_t     i_rsp_ram,
  input  wire apb_rsp_t     i_rsp_led,
  input  wire apb_rsp_t     i_rsp_uart,
  output logic              o_ready,
  output logic [31:0]       o_rdata,
  output logic              o_error
);

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_DONE} state_e;

  state_e       state;
  decoded_req_t req_q;
  apb_rsp_t     sel_rsp;
  logic         in_xfer;
  logic         accept;

  assign accept  = (state == ST_IDLE) && i_req_valid;
  assign in_xfer = (state == ST_SETUP) || (state == ST_ACCESS);

  // Request fields are held from SETUP until completion
  assign o_apb = '{paddr: req_q.offset, pwrite: req_q.write,
                   pwdata: req_q.wdata, penable: (state == ST_ACCESS)};

  assign o_psel_ram  = in_xfer && (req_q.region == REGION_RAM);
  assign o_psel_led  = in_xfer && (req_q.region == REGION_LED);
  assign o_psel_uart = in_xfer && (req_q.region == REGION_UART);

  always_comb begin
    case (req_q.region)
      REGION_RAM:  sel_rsp = i_rsp_ram;
      REGION_LED:  sel_rsp = i_rsp_led;
      REGION_UART: sel_rsp = i_rsp_uart;
      default:     sel_rsp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
    endcase
  end

  always_ff @(posedge CLOCK_50_B5B) begin
    if (i_reset) begin
      state   <= ST_IDLE;
      o_ready <= 1'b0;
      o_error <= 1'b0;
    end else begin
      o_ready <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_req_valid && (i_dec.region == REGION_NONE)) begin
            state   <= ST_DONE;
            o_ready <= 1'b1;
            o_error <= 1'b1;
          end else if (i_req_valid) begin
            state <= ST_SETUP;
          end
        end
        ST_SETUP: state <= ST_ACCESS;
        ST_ACCESS: begin
          // Wait states from the completer
          if (sel_rsp.pready) begin
            state   <= ST_DONE;
            o_ready <= 1'b1;
            o_error <= sel_rsp.pslverr;
          end
        end
        default: begin
          state   <= ST_IDLE;
          o_error <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge CLOCK_50_B5B) begin
    if (accept) begin
      req_q   <= i_dec;
      o_rdata <= '0;
    end else if ((state == ST_ACCESS) && sel_rsp.pready) begin
      o_rdata <= sel_rsp.pslverr ? '0 : sel_rsp.prdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/apb_ram.sv ====
//**************************************************
// Zero-wait APB RAM, word addressed
// Byte lanes are not supported, whole words only
// A read returns the word as of the SETUP cycle
//**************************************************
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module apb_ram
  import soc_pkg::*;
(
  input  wire logic     CLOCK_50_B5B,
  input  wire logic     i_psel,
  input  wire apb_req_t i_apb,
  output apb_rsp_t      o_rsp
);

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  logic [31:0]      mem [`SOC_RAM_WORDS];
  logic [31:0]      rdata_q;
  logic [IDX_W-1:0] idx;

  // Low two address bits select a byte and are dropped
  assign idx = i_apb.paddr[IDX_W+1:2];

  always_ff @(posedge CLOCK_50_B5B) begin
    if (i_psel && !i_apb.penable) begin
      rdata_q <= mem[idx];
    end
    if (i_psel && i_apb.penable && i_apb.pwrite) begin
      mem[idx] <= i_apb.pwdata;
    end
  end

  assign o_rsp = '{prdata: rdata_q, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

// ==== source/led_regs.sv ====
//**************************************************
// LED register on APB, zero wait
// Every offset in the window maps to one register
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module led_regs
  import soc_pkg::*;
(
  input  wire logic     CLOCK_50_B5B,
  input  wire logic     i_reset,
  input  wire logic     i_psel,
  input  wire apb_req_t i_apb,
  output apb_rsp_t      o_rsp,
  output logic [9:0]    o_leds
);

  always_ff @(posedge CLOCK_50_B5B) begin
    if (i_reset) begin
      o_leds <= '0;
    end else if (i_psel && i_apb.penable && i_apb.pwrite) begin
      // Only the low ten bits reach the red LEDs
      o_leds <= i_apb.pwdata[9:0];
    end
  end

  assign o_rsp = '{prdata: {22'b0, o_leds}, pready: 1'b1, pslverr: 1'b0};

endmodule

`default_nettype wire

// ==== source/soc_bus.sv ====
//**************************************************
// Peripheral fabric top level
// One request in flight, held until o_ready
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module soc_bus
  import soc_pkg::*;
#(
  parameter int UART_CLKS_PER_BIT = 5208
) (
  input  wire logic     CLOCK_50_B5B,
  input  wire logic     i_reset,
  input  wire logic     i_req_valid,
  input  wire cpu_req_t i_req,
  output logic          o_ready,
  output logic [31:0]   o_rdata,
  output logic          o_error,
  output logic [9:0]    o_leds,
  output logic          o_uart_tx
);

  decoded_req_t dec;
  apb_req_t     apb;
  apb_rsp_t     rsp_ram;
  apb_rsp_t     rsp_led;
  apb_rsp_t     rsp_uart;
  logic         psel_ram;
  logic         psel_led;
  logic         psel_uart;

  address_decoder u_decoder (
    .i_req (i_req),
    .o_dec (dec)
  );

  apb_bridge u_bridge (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_reset      (i_reset),
    .i_req_valid  (i_req_valid),
    .i_dec        (dec),
    .o_apb        (apb),
    .o_psel_ram   (psel_ram),
    .o_psel_led   (psel_led),
    .o_psel_uart  (psel_uart),
    .i_rsp_ram    (rsp_ram),
    .i_rsp_led    (rsp_led),
    .i_rsp_uart   (rsp_uart),
    .o_ready      (o_ready),
    .o_rdata      (o_rdata),
    .o_error      (o_error)
  );

  apb_ram u_ram (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_psel       (psel_ram),
    .i_apb        (apb),
    .o_rsp        (rsp_ram)
  );

  led_regs u_leds (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_reset      (i_reset),
    .i_psel       (psel_led),
    .i_apb        (apb),
    .o_rsp        (rsp_led),
    .o_leds       (o_leds)
  );

  uart_tx #(
    .UART_CLKS_PER_BIT (UART_CLKS_PER_BIT)
  ) u_uart (
    .CLOCK_50_B5B (CLOCK_50_B5B),
    .i_reset      (i_reset),
    .i_psel       (psel_uart),
    .i_apb        (apb),
    .o_rsp        (rsp_uart),
    .o_uart_tx    (o_uart_tx)
  );

endmodule

`default_nettype wire

// ==== source/soc_defines.svh ====
//**************************************************
// Address map of the peripheral fabric
// Windows must not overlap and must end below 2^32
// UART offsets are relative to SOC_UART_BASE
//**************************************************
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// On-chip RAM, 32 KB of 32-bit words
`define SOC_RAM_BASE  32'h0002_0000
`define SOC_RAM_SIZE  32'h0000_8000
`define SOC_RAM_WORDS 8192

`define SOC_LED_BASE  32'h1000_0000
`define SOC_LED_SIZE  32'h1000_0000

// UART data is write only, status is read only
`define SOC_UART_BASE       32'h2000_0000
`define SOC_UART_SIZE       32'h1000_0000
`define SOC_UART_DATA_OFS   32'h0000_0000
`define SOC_UART_STATUS_OFS 32'h0000_0004
`define SOC_UART_BUSY_BIT   0

`endif

// ==== source/soc_pkg.sv ====
//**************************************************
// Shared types of the processor port and APB fabric
// One APB request bus is shared by all completers
//**************************************************
`default_nettype none

package soc_pkg;

  // Target of a processor request
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_LED,
    REGION_UART,
    REGION_NONE
  } region_e;

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
  } cpu_req_t;

  // Request after address decode, offset is relative to the window base
  typedef struct packed {
    region_e     region;
    logic [31:0] offset;
    logic        write;
    logic [31:0] wdata;
  } decoded_req_t;

  typedef struct packed {
    logic [31:0] paddr;
    logic        pwrite;
    logic [31:0] pwdata;
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== source/uart_tx.sv ====
//**************************************************
// UART transmitter on APB, 8N1 framing
// A data write stalls with pready low while busy
// Wrong direction or unknown offset gives pslverr
//**************************************************
`timescale 1ns/1ns
`default_nettype none

`include "soc_defines.svh"

module uart_tx
  import soc_pkg::*;
#(
  parameter int UART_CLKS_PER_BIT = 5208
) (
  input  wire logic     CLOCK_50_B5B,
  input  wire logic     i_reset,
  input  wire logic     i_psel,
  input  wire apb_req_t i_apb,
  output apb_rsp_t      o_rsp,
  output logic          o_uart_tx
);

  localparam int CNT_W = $clog2(UART_CLKS_PER_BIT + 1);

  logic             busy;
  logic [8:0]       shift_q;
  logic [3:0]       bit_cnt;
  logic [CNT_W-1:0] clk_cnt;
  logic             is_data;
  logic             is_status;
  logic             bad_access;
  logic             load;
  logic [31:0]      status;

  assign is_data    = (i_apb.paddr == `SOC_UART_DATA_OFS);
  assign is_status  = (i_apb.paddr == `SOC_UART_STATUS_OFS);
  assign bad_access = !((is_data && i_apb.pwrite) || (is_status && !i_apb.pwrite));
  assign load = i_psel && i_apb.penable && i_apb.pwrite && is_data && !busy;

  always_comb begin
    status = '0;
    status[`SOC_UART_BUSY_BIT] = busy;
    o_rsp.pslverr = bad_access;
    o_rsp.prdata  = (is_status && !bad_access) ? status : '0;
    // Back-pressure only for a valid data write
    o_rsp.pready  = bad_access || is_status || !busy;
  end

  always_ff @(posedge CLOCK_50_B5B) begin
    if (i_reset) begin
      busy      <= 1'b0;
      o_uart_tx <= 1'b1;
      bit_cnt   <= '0;
      clk_cnt   <= '0;
    end else if (load) begin
      busy      <= 1'b1;
      o_uart_tx <= 1'b0;
      bit_cnt   <= '0;
      clk_cnt   <= '0;
    end else if (busy) begin
      if (clk_cnt == CNT_W'(UART_CLKS_PER_BIT - 1)) begin
        clk_cnt <= '0;
        // Stop bit has been held for a full period
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
        end else begin
          o_uart_tx <= shift_q[0];
          bit_cnt   <= bit_cnt + 4'd1;
        end
      end else begin
        clk_cnt <= clk_cnt + CNT_W'(1);
      end
    end
  end

  // Data LSB first, stop bit on top, ones fill in behind
  always_ff @(posedge CLOCK_50_B5B) begin
    if (load) begin
      shift_q <= {1'b1, i_apb.pwdata[7:0]};
    end else if (busy && (clk_cnt == CNT_W'(UART_CLKS_PER_BIT - 1))) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

`default_nettype wire
